// ==== common/wasm_pkg.sv ====
package wasm_pkg;

    localparam int window_bytes = 8;
    localparam int leb_bytes    = 5;
    localparam int word_width   = 32;

    typedef logic [window_bytes*8-1:0] window_t;   // byte 0 in bits 7:0
    typedef logic [leb_bytes*8-1:0]    leb_t;

    // "\0asm" then version 1, little endian
    localparam window_t    wasm_magic_version = 64'h0000_0001_6d73_6100;
    localparam logic [7:0] code_section_id    = 8'h0a;

    typedef enum logic [7:0] {
        op_nop        = 8'h01,
        op_drop       = 8'h1a,
        op_select     = 8'h1b,
        op_local_get  = 8'h20,
        op_local_set  = 8'h21,
        op_local_tee  = 8'h22,
        op_i32_load   = 8'h28,
        op_i32_store  = 8'h36,
        op_i32_const  = 8'h41,
        op_i32_eqz    = 8'h45,
        op_i32_eq     = 8'h46,
        op_i32_ne     = 8'h47,
        op_i32_lt_s   = 8'h48,
        op_i32_lt_u   = 8'h49,
        op_i32_gt_s   = 8'h4a,
        op_i32_gt_u   = 8'h4b,
        op_i32_le_s   = 8'h4c,
        op_i32_le_u   = 8'h4d,
        op_i32_ge_s   = 8'h4e,
        op_i32_ge_u   = 8'h4f,
        op_i32_add    = 8'h6a,
        op_i32_sub    = 8'h6b,
        op_i32_and    = 8'h71,
        op_i32_or     = 8'h72,
        op_i32_shl    = 8'h74,
        op_i32_shr_s  = 8'h75,
        op_i32_shr_u  = 8'h76,
        op_i32_rotl   = 8'h77,
        op_i32_rotr   = 8'h78
    } opcode_e;

    typedef enum logic [4:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_select,
        alu_eqz, alu_eq,
        alu_lt_u, alu_gt_u, alu_le_u, alu_ge_u,
        alu_lt_s, alu_gt_s, alu_le_s, alu_ge_s,
        alu_ne,
        alu_shl, alu_shr_s, alu_shr_u, alu_rotl, alu_rotr
    } alu_op_e;

    // push_none is zero so an idle bundle is all zeros
    typedef enum logic [2:0] {
        push_none  = 3'd0,
        push_alu   = 3'd1,
        push_imm   = 3'd2,
        push_mem   = 3'd3,
        push_local = 3'd4
    } push_src_e;

    typedef enum logic [1:0] {
        module_head,
        section_head,
        vector_head,
        vector_content
    } phase_e;

    typedef struct packed {
        logic [1:0] pop_num;
        logic       push_num;
        push_src_e  push_src;
        alu_op_e    alu_op;
        logic       load_en;
        logic       store_en;
        logic       local_get;
        logic       local_set;
        logic       illegal;
    } ctrl_t;

    typedef struct packed {
        logic                  is_instr;
        logic                  error;
        logic [word_width-1:0] advance_minus_one;
        logic [word_width-1:0] imm;
        ctrl_t                 ctrl;
    } result_t;

endpackage

// ==== logic/opcode_decoder.sv ====
`timescale 1ns/1ps

module opcode_decoder (
    input  logic [7:0]                        opcode,
    input  logic [2:0]                        imm_len,
    output wasm_pkg::ctrl_t                   ctrl,
    output logic [wasm_pkg::word_width-1:0]   advance_minus_one
);

    logic                            binary;
    logic [wasm_pkg::word_width-1:0] imm_adv;

    assign imm_adv = {29'd0, imm_len};

    always_comb begin
        ctrl              = '0;
        ctrl.push_src     = wasm_pkg::push_none;
        advance_minus_one = '0;
        binary            = 1'b0;
        case (wasm_pkg::opcode_e'(opcode))
            wasm_pkg::op_nop: begin
            end
            wasm_pkg::op_drop: begin
                ctrl.pop_num = 2'd1;
            end
            wasm_pkg::op_select: begin
                ctrl.pop_num  = 2'd3;
                ctrl.push_num = 1'b1;
                ctrl.push_src = wasm_pkg::push_alu;
                ctrl.alu_op   = wasm_pkg::alu_select;
            end
            wasm_pkg::op_i32_eqz: begin
                ctrl.pop_num  = 2'd1;
                ctrl.push_num = 1'b1;
                ctrl.push_src = wasm_pkg::push_alu;
                ctrl.alu_op   = wasm_pkg::alu_eqz;
            end
            wasm_pkg::op_i32_const: begin
                ctrl.push_num     = 1'b1;
                ctrl.push_src     = wasm_pkg::push_imm;
                advance_minus_one = imm_adv;
            end
            wasm_pkg::op_local_get: begin
                ctrl.push_num     = 1'b1;
                ctrl.push_src     = wasm_pkg::push_local;
                ctrl.local_get    = 1'b1;
                advance_minus_one = imm_adv;
            end
            wasm_pkg::op_local_set: begin
                ctrl.pop_num      = 2'd1;
                ctrl.local_set    = 1'b1;
                advance_minus_one = imm_adv;
            end
            wasm_pkg::op_local_tee: begin
                ctrl.local_set    = 1'b1;  // top stays on the stack
                advance_minus_one = imm_adv;
            end
            wasm_pkg::op_i32_load: begin
                ctrl.pop_num      = 2'd1;
                ctrl.push_num     = 1'b1;
                ctrl.push_src     = wasm_pkg::push_mem;
                ctrl.alu_op       = wasm_pkg::alu_add;  // address calc
                ctrl.load_en      = 1'b1;
                advance_minus_one = imm_adv + 32'd1;    // align and offset
            end
            wasm_pkg::op_i32_store: begin
                ctrl.pop_num      = 2'd2;
                ctrl.alu_op       = wasm_pkg::alu_add;
                ctrl.store_en     = 1'b1;
                advance_minus_one = imm_adv + 32'd1;
            end
            wasm_pkg::op_i32_eq:    begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_eq;    end
            wasm_pkg::op_i32_ne:    begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_ne;    end
            wasm_pkg::op_i32_lt_s:  begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_lt_s;  end
            wasm_pkg::op_i32_lt_u:  begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_lt_u;  end
            wasm_pkg::op_i32_gt_s:  begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_gt_s;  end
            wasm_pkg::op_i32_gt_u:  begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_gt_u;  end
            wasm_pkg::op_i32_le_s:  begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_le_s;  end
            wasm_pkg::op_i32_le_u:  begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_le_u;  end
            wasm_pkg::op_i32_ge_s:  begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_ge_s;  end
            wasm_pkg::op_i32_ge_u:  begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_ge_u;  end
            wasm_pkg::op_i32_add:   begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_add;   end
            wasm_pkg::op_i32_sub:   begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_sub;   end
            wasm_pkg::op_i32_and:   begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_and;   end
            wasm_pkg::op_i32_or:    begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_or;    end
            wasm_pkg::op_i32_shl:   begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_shl;   end
            wasm_pkg::op_i32_shr_s: begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_shr_s; end
            wasm_pkg::op_i32_shr_u: begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_shr_u; end
            wasm_pkg::op_i32_rotl:  begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_rotl;  end
            wasm_pkg::op_i32_rotr:  begin binary = 1'b1; ctrl.alu_op = wasm_pkg::alu_rotr;  end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
        if (binary) begin
            ctrl.pop_num  = 2'd2;   // two operands, one result
            ctrl.push_num = 1'b1;
            ctrl.push_src = wasm_pkg::push_alu;
        end
    end

endmodule

// ==== logic/wasm_ctrl.sv ====
`timescale 1ns/1ps

module wasm_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  wasm_pkg::window_t   window,
    output logic                ack,
    output wasm_pkg::result_t   result
);

    wasm_pkg::phase_e                  phase;
    wasm_pkg::leb_t                    head_bytes;
    logic [wasm_pkg::word_width-1:0]   head_value;
    logic [2:0]                        head_len;
    logic [wasm_pkg::word_width-1:0]   imm_value;
    logic [2:0]                        imm_len;
    wasm_pkg::ctrl_t                   instr_ctrl;
    logic [wasm_pkg::word_width-1:0]   instr_advance;

    // vector count sits at byte 0, section length after the type byte
    assign head_bytes = (phase == wasm_pkg::vector_head) ? window[39:0] : window[47:8];

    leb128_decoder u_head_leb (
        .bytes    (head_bytes),
        .value    (head_value),
        .byte_cnt (head_len)
    );

    leb128_decoder u_imm_leb (
        .bytes    (window[47:8]),
        .value    (imm_value),
        .byte_cnt (imm_len)
    );

    opcode_decoder u_opcode_decoder (
        .opcode            (window[7:0]),
        .imm_len           (imm_len),
        .ctrl              (instr_ctrl),
        .advance_minus_one (instr_advance)
    );

    section_walker u_section_walker (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .window        (window),
        .head_len      (head_len),
        .head_value    (head_value),
        .instr_ctrl    (instr_ctrl),
        .instr_advance (instr_advance),
        .imm_value     (imm_value),
        .ack           (ack),
        .phase         (phase),
        .result        (result)
    );

endmodule

// ==== parser/leb128_decoder.sv ====
`timescale 1ns/1ps

module leb128_decoder (
    input  wasm_pkg::leb_t                     bytes,
    output logic [wasm_pkg::word_width-1:0]    value,
    output logic [2:0]                         byte_cnt
);

    logic done;

    always_comb begin
        value    = '0;
        byte_cnt = 3'(wasm_pkg::leb_bytes);    // no terminator found
        done     = 1'b0;
        for (int i = 0; i < wasm_pkg::leb_bytes; i++) begin
            if (!done) begin
                // top group only keeps its low 4 bits
                value = value | (32'(bytes[8*i +: 7]) << (7*i));
                if (!bytes[8*i+7]) begin
                    byte_cnt = 3'(i + 1);
                    done     = 1'b1;
                end
            end
        end
    end

endmodule

// ==== parser/section_walker.sv ====
`timescale 1ns/1ps

module section_walker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req,
    input  wasm_pkg::window_t                 window,
    input  logic [2:0]                        head_len,
    input  logic [wasm_pkg::word_width-1:0]   head_value,
    input  wasm_pkg::ctrl_t                   instr_ctrl,
    input  logic [wasm_pkg::word_width-1:0]   instr_advance,
    input  logic [wasm_pkg::word_width-1:0]   imm_value,
    output logic                              ack,
    output wasm_pkg::phase_e                  phase,
    output wasm_pkg::result_t                 result
);

    logic                              req_q;
    logic                              accept;
    logic                              error;
    logic                              error_next;
    logic                              header_ok;
    logic                              is_code;
    logic [7:0]                        section_type;
    logic [wasm_pkg::word_width-1:0]   section_len;
    logic [wasm_pkg::word_width-1:0]   items_left;
    wasm_pkg::phase_e                  phase_next;
    wasm_pkg::result_t                 result_next;

    assign accept    = req_q && !ack;   // one window per req pulse
    assign header_ok = (window == wasm_pkg::wasm_magic_version) && !error;
    assign is_code   = section_type == wasm_pkg::code_section_id;

    always_comb begin
        result_next               = '0;
        result_next.ctrl.push_src = wasm_pkg::push_none;
        phase_next                = phase;
        error_next                = error;
        case (phase)
            wasm_pkg::module_head: begin
                result_next.advance_minus_one = 32'd7;
                if (header_ok) begin
                    phase_next = wasm_pkg::section_head;
                end else begin
                    error_next = 1'b1;      // stuck here until reset
                end
            end
            wasm_pkg::section_head: begin
                result_next.advance_minus_one = {29'd0, head_len};  // type byte plus length
                phase_next = wasm_pkg::vector_head;
            end
            wasm_pkg::vector_head: begin
                if (is_code) begin
                    result_next.advance_minus_one = {29'd0, head_len} - 32'd1;
                    if (head_value == '0) begin
                        phase_next = wasm_pkg::section_head;
                    end else begin
                        phase_next = wasm_pkg::vector_content;
                    end
                end else begin
                    // skip the rest of the section in one step
                    result_next.advance_minus_one = section_len - 32'd1;
                    phase_next = wasm_pkg::section_head;
                end
            end
            default: begin
                result_next.is_instr          = 1'b1;
                result_next.imm               = imm_value;
                result_next.advance_minus_one = instr_advance;
                result_next.ctrl              = instr_ctrl;
                if (items_left == 32'd1) begin
                    phase_next = wasm_pkg::section_head;   // last item
                end
            end
        endcase
        result_next.error = error_next;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q        <= 1'b0;
            ack          <= 1'b0;
            phase        <= wasm_pkg::module_head;
            error        <= 1'b0;
            section_type <= '0;
            section_len  <= '0;
            items_left   <= '0;
            result       <= '0;
        end else begin
            req_q <= req;
            if (accept) begin
                ack    <= 1'b1;
                phase  <= phase_next;
                error  <= error_next;
                result <= result_next;
                case (phase)
                    wasm_pkg::section_head: begin
                        section_type <= window[7:0];
                        section_len  <= head_value;
                    end
                    wasm_pkg::vector_head: begin
                        items_left <= head_value;
                    end
                    wasm_pkg::vector_content: begin
                        items_left <= items_left - 32'd1;
                    end
                    default: begin
                    end
                endcase
            end else if (!req_q && ack) begin
                ack <= 1'b0;    // source released req
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the wasm_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f wasm_ctrl.f --top-module tb_wasm_ctrl -o sim_wasm_ctrl
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_wasm_ctrl +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Done: no errors$"; then
    exit 0
fi
exit 1

// ==== test/tb_wasm_ctrl.sv ====
`timescale 1ns/1ps

module tb_wasm_ctrl;

    localparam int num_consts     = 8;
    localparam int num_windows    = 48;
    localparam int timeout_cycles = 10 * num_windows + 100;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              req;
    wasm_pkg::window_t window;
    logic              ack;
    wasm_pkg::result_t result;
    int                cycle_count = 0;
    logic [7:0]        ops [$];
    logic [39:0]       field;
    logic [31:0]       value;

    wasm_ctrl dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .window (window),
        .ack    (ack),
        .result (result)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Done: errors found");
            $fatal(1, "timeout after %0d cycles, handshake never completed", cycle_count);
        end
    end

    // stop at the first failed check in the bound checker
    always @(negedge clk) begin
        if (dut.u_assert.fail_count != 0) begin
            $display("Done: errors found");
            $fatal(1, "checker reported %0d failed assertion(s)", dut.u_assert.fail_count);
        end
    end

    function automatic logic [39:0] leb_encode(input logic [31:0] v);
        logic [39:0] b;
        logic [31:0] rest;
        b    = '0;
        rest = v;
        for (int i = 0; i < 5; i++) begin
            b[8*i +: 7] = rest[6:0];
            rest = rest >> 7;
            if (rest == 0) break;
            b[8*i+7] = 1'b1;    // more groups follow
        end
        return b;
    endfunction

    function automatic wasm_pkg::window_t pack_window(input logic [7:0] first,
                                                      input logic [39:0] rest);
        return {16'h0, rest, first};
    endfunction

    task automatic send_window(input wasm_pkg::window_t w);
        @(posedge clk);
        window <= w;
        req    <= 1'b1;
        @(posedge clk);
        while (!ack) @(posedge clk);
        req <= 1'b0;
        @(posedge clk);
        while (ack) @(posedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    initial begin
        rst_n  = 1'b0;
        req    = 1'b0;
        window = '0;
        void'($urandom(25));
        ops = '{8'h01, 8'h1a, 8'h1b, 8'h20, 8'h21, 8'h22, 8'h28, 8'h36, 8'h41, 8'h45,
                8'h46, 8'h47, 8'h48, 8'h49, 8'h4a, 8'h4b, 8'h4c, 8'h4d, 8'h4e, 8'h4f,
                8'h6a, 8'h6b, 8'h71, 8'h72, 8'h74, 8'h75, 8'h76, 8'h77, 8'h78, 8'h0b};

        apply_reset();
        send_window(wasm_pkg::wasm_magic_version ^ 64'h1);     // corrupt magic
        send_window(wasm_pkg::wasm_magic_version);             // error still set
        apply_reset();
        send_window(wasm_pkg::wasm_magic_version);

        send_window(pack_window(8'h00, leb_encode(32'h123)));   // custom section
        send_window({$urandom, $urandom});

        send_window(pack_window(8'h0a, leb_encode(32'd200)));
        send_window({24'h0, leb_encode(32'(ops.size() + num_consts))});
        foreach (ops[i]) begin
            case (ops[i])
                8'h41: field = leb_encode($urandom);
                8'h20, 8'h21, 8'h22: field = leb_encode(32'd300);
                8'h28, 8'h36: field = 40'h10_02;    // align 2, offset 16
                default: field = '0;
            endcase
            send_window(pack_window(ops[i], field));
        end
        repeat (num_consts) begin
            value = $urandom;
            value = value >> value[4:0];    // spread over 1 to 5 bytes
            send_window(pack_window(8'h41, leb_encode(value)));
        end

        send_window(pack_window(8'h0a, leb_encode(32'd1)));    // empty code section
        send_window({24'h0, leb_encode(32'd0)});
        send_window(pack_window(8'h0b, leb_encode(32'd5)));
        repeat (4) @(posedge clk);

        if (dut.u_assert.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "checker reported failed assertions");
        end
    end

endmodule

// ==== test/wasm_ctrl_assert.sv ====
`timescale 1ns/1ps

module wasm_ctrl_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              req,
    input wasm_pkg::window_t window,
    input logic              ack,
    input wasm_pkg::result_t result
);

    int                 fail_count = 0;
    logic               ack_q;
    logic               rose;
    logic               err_m;
    wasm_pkg::phase_e   ph;
    logic [7:0]         sec_type;
    logic [31:0]        sec_len;
    logic [31:0]        items;
    logic [34:0]        at0;    // {byte count, value} of field at byte 0
    logic [34:0]        at1;    // same, field at byte 1
    wasm_pkg::result_t  exp;

    function automatic logic [34:0] decode_leb(input logic [39:0] b);
        logic [31:0] v;
        logic [2:0]  n;
        v = '0;
        n = 3'd5;
        for (int i = 4; i >= 0; i--) begin
            if (!b[8*i+7]) n = 3'(i + 1);   // lowest terminator wins
        end
        for (int i = 0; i < 5; i++) begin
            if (i < int'(n)) v = v | (32'(b[8*i +: 7]) << (7*i));
        end
        return {n, v};
    endfunction

    function automatic wasm_pkg::ctrl_t bundle(input logic [1:0] pop, input logic push,
                                               input wasm_pkg::push_src_e src,
                                               input wasm_pkg::alu_op_e op,
                                               input logic [4:0] flags);
        return {pop, push, src, op, flags};     // flags: load store get set illegal
    endfunction

    function automatic wasm_pkg::ctrl_t expected_ctrl(input logic [7:0] op);
        case (op)
            8'h01: return bundle(2'd0, 1'b0, wasm_pkg::push_none, wasm_pkg::alu_add, 5'b00000);
            8'h1a: return bundle(2'd1, 1'b0, wasm_pkg::push_none, wasm_pkg::alu_add, 5'b00000);
            8'h1b: return bundle(2'd3, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_select, 5'b00000);
            8'h20: return bundle(2'd0, 1'b1, wasm_pkg::push_local, wasm_pkg::alu_add, 5'b00100);
            8'h21: return bundle(2'd1, 1'b0, wasm_pkg::push_none, wasm_pkg::alu_add, 5'b00010);
            8'h22: return bundle(2'd0, 1'b0, wasm_pkg::push_none, wasm_pkg::alu_add, 5'b00010);
            8'h28: return bundle(2'd1, 1'b1, wasm_pkg::push_mem, wasm_pkg::alu_add, 5'b10000);
            8'h36: return bundle(2'd2, 1'b0, wasm_pkg::push_none, wasm_pkg::alu_add, 5'b01000);
            8'h41: return bundle(2'd0, 1'b1, wasm_pkg::push_imm, wasm_pkg::alu_add, 5'b00000);
            8'h45: return bundle(2'd1, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_eqz, 5'b00000);
            8'h46: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_eq, 5'b00000);
            8'h47: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_ne, 5'b00000);
            8'h48: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_lt_s, 5'b00000);
            8'h49: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_lt_u, 5'b00000);
            8'h4a: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_gt_s, 5'b00000);
            8'h4b: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_gt_u, 5'b00000);
            8'h4c: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_le_s, 5'b00000);
            8'h4d: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_le_u, 5'b00000);
            8'h4e: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_ge_s, 5'b00000);
            8'h4f: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_ge_u, 5'b00000);
            8'h6a: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_add, 5'b00000);
            8'h6b: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_sub, 5'b00000);
            8'h71: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_and, 5'b00000);
            8'h72: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_or, 5'b00000);
            8'h74: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_shl, 5'b00000);
            8'h75: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_shr_s, 5'b00000);
            8'h76: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_shr_u, 5'b00000);
            8'h77: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_rotl, 5'b00000);
            8'h78: return bundle(2'd2, 1'b1, wasm_pkg::push_alu, wasm_pkg::alu_rotr, 5'b00000);
            default: return bundle(2'd0, 1'b0, wasm_pkg::push_none, wasm_pkg::alu_add, 5'b00001);
        endcase
    endfunction

    assign rose = ack && !ack_q;
    assign at0  = decode_leb(window[39:0]);
    assign at1  = decode_leb(window[47:8]);

    always_comb begin
        exp = '0;
        case (ph)
            wasm_pkg::module_head: begin
                exp.advance_minus_one = 32'd7;
                exp.error = err_m || (window != wasm_pkg::wasm_magic_version);
            end
            wasm_pkg::section_head: begin
                exp.advance_minus_one = 32'(at1[34:32]);
            end
            wasm_pkg::vector_head: begin
                if (sec_type == wasm_pkg::code_section_id) begin
                    exp.advance_minus_one = 32'(at0[34:32]) - 32'd1;
                end else begin
                    exp.advance_minus_one = sec_len - 32'd1;    // whole section skipped
                end
            end
            default: begin
                exp.is_instr = 1'b1;
                exp.imm      = at1[31:0];
                exp.ctrl     = expected_ctrl(window[7:0]);
                case (window[7:0])
                    8'h20, 8'h21, 8'h22, 8'h41: exp.advance_minus_one = 32'(at1[34:32]);
                    8'h28, 8'h36: exp.advance_minus_one = 32'(at1[34:32]) + 32'd1;
                    default: begin
                    end
                endcase
            end
        endcase
    end

    // reference walk, updated once per accepted window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            err_m    <= 1'b0;
            ph       <= wasm_pkg::module_head;
            sec_type <= '0;
            sec_len  <= '0;
            items    <= '0;
        end else begin
            ack_q <= ack;
            if (rose) begin
                err_m <= exp.error;
                case (ph)
                    wasm_pkg::module_head: begin
                        if (!exp.error) ph <= wasm_pkg::section_head;
                    end
                    wasm_pkg::section_head: begin
                        sec_type <= window[7:0];
                        sec_len  <= at1[31:0];
                        ph       <= wasm_pkg::vector_head;
                    end
                    wasm_pkg::vector_head: begin
                        items <= at0[31:0];
                        if (sec_type == wasm_pkg::code_section_id && at0[31:0] != 0) begin
                            ph <= wasm_pkg::vector_content;
                        end else begin
                            ph <= wasm_pkg::section_head;
                        end
                    end
                    default: begin
                        items <= items - 32'd1;
                        if (items == 32'd1) ph <= wasm_pkg::section_head;
                    end
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
        else begin
            fail_count = fail_count + 1;
            $error("ack rose while req was low");
        end

    assert property (@(posedge clk) disable iff (!rst_n) !$past(rst_n) |-> !ack)
        else begin
            fail_count = fail_count + 1;
            $error("ack was high right after reset");
        end

    assert property (@(posedge clk) disable iff (!rst_n) ack && $past(ack) |-> $stable(result))
        else begin
            fail_count = fail_count + 1;
            $error("MISMATCH result changed while ack high: was %h now %h",
                   $past(result), result);
        end

    assert property (@(posedge clk) disable iff (!rst_n) rose |-> result == exp)
        else begin
            fail_count = fail_count + 1;
            $error("MISMATCH result expected %h got %h", exp, result);
        end

    assert property (@(posedge clk) disable iff (!rst_n) result.error |=> result.error)
        else begin
            fail_count = fail_count + 1;
            $error("result.error dropped before reset");
        end

endmodule

bind wasm_ctrl wasm_ctrl_assert u_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .window (window),
    .ack    (ack),
    .result (result)
);

// ==== wasm_ctrl.f ====
common/wasm_pkg.sv
parser/leb128_decoder.sv
parser/section_walker.sv
logic/opcode_decoder.sv
logic/wasm_ctrl.sv
test/wasm_ctrl_assert.sv
test/tb_wasm_ctrl.sv
